/* rvCore.f */
+incdir+.
rvIsaPkg.sv
rvCtrlPkg.sv
rvStageIf.sv
decodeStage.sv
regFile.sv
executeStage.sv
memWbStage.sv
rvCore.sv
tb_rvCore.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rvCore
FILELIST = rvCore.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rvCore_stimulus.txt */
// columns: instruction, expected aluResult, flags (zero*4 + branchTaken*2 + error),
// register index checked after the edge, expected register value
00500013 00000005 0 00 00000000 // addi x0, x0, 5
00500093 00000005 0 01 00000005 // addi x1, x0, 5
FFD00113 FFFFFFFD 0 02 FFFFFFFD // addi x2, x0, -3
002081B3 00000002 0 03 00000002 // add x3, x1, x2
40108233 00000000 4 04 00000000 // sub x4, x1, x1
402082B3 00000008 0 05 00000008 // sub x5, x1, x2
00409313 00000050 0 06 00000050 // slli x6, x1, 4
00415393 0FFFFFFF 0 07 0FFFFFFF // srli x7, x2, 4
40415413 FFFFFFFF 0 08 FFFFFFFF // srai x8, x2, 4
001124B3 00000001 0 09 00000001 // slt x9, x2, x1
00113533 00000000 4 0A 00000000 // sltu x10, x2, x1
0FF0C593 000000FA 0 0B 000000FA // xori x11, x1, 0xff
00136633 00000055 0 0C 00000055 // or x12, x6, x1
00B676B3 00000050 0 0D 00000050 // and x13, x12, x11
00109733 000000A0 0 0E 000000A0 // sll x14, x1, x1
401157B3 FFFFFFFF 0 0F FFFFFFFF // sra x15, x2, x1
ABC07837 ABC07000 0 10 ABC07000 // lui x16, 0xabc07
876548B7 87654000 0 11 87654000 // lui x17, 0x87654
32188893 87654321 0 11 87654321 // addi x17, x17, 0x321
01102823 00000010 0 10 ABC07000 // sw x17, 16(x0)
01002903 00000010 0 12 87654321 // lw x18, 16(x0)
01300983 00000013 0 13 FFFFFF87 // lb x19, 19(x0)
01304A03 00000013 0 14 00000087 // lbu x20, 19(x0)
01201A83 00000012 0 15 FFFF8765 // lh x21, 18(x0)
01205B03 00000012 0 16 00008765 // lhu x22, 18(x0)
01001B83 00000010 0 17 00004321 // lh x23, 16(x0)
01101B23 00000016 0 16 00008765 // sh x17, 22(x0)
01100AA3 00000015 0 15 FFFF8765 // sb x17, 21(x0)
01402C03 00000014 0 18 43212100 // lw x24, 20(x0)
01500C83 00000015 0 19 00000021 // lb x25, 21(x0)
00108463 00000000 6 08 FFFFFFFF // beq x1, x1
00208463 00000008 0 08 FFFFFFFF // beq x1, x2
00209463 00000008 2 08 FFFFFFFF // bne x1, x2
00109463 00000000 4 08 FFFFFFFF // bne x1, x1
00114463 FFFFFFF8 2 08 FFFFFFFF // blt x2, x1
0020C463 00000008 0 08 FFFFFFFF // blt x1, x2
0020D463 00000008 2 08 FFFFFFFF // bge x1, x2
00115463 FFFFFFF8 0 08 FFFFFFFF // bge x2, x1
0020E463 00000008 2 08 FFFFFFFF // bltu x1, x2
00116463 FFFFFFF8 0 08 FFFFFFFF // bltu x2, x1
00117463 FFFFFFF8 2 08 FFFFFFFF // bgeu x2, x1
0020F463 00000008 0 08 FFFFFFFF // bgeu x1, x2
000000EF 00000000 5 01 00000005 // jal x1, 0
00000297 00000000 5 05 00000008 // auipc x5, 0
00002827 00000000 5 10 ABC07000 // store-fp opcode, x0 to 16(x0)
01002D03 00000010 0 1A 87654321 // lw x26, 16(x0)

/* tb_rvCore.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module tb_rvCore;

    localparam int MaxVec = 64;          // room in the vector array
    localparam int Cols   = 5;           // words per vector
    localparam logic [31:0] EndMark = '1; // unused slots keep this

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] instruction;
    logic [`XLEN-1:0] aluResult;
    logic             zeroFlag;
    logic             branchTaken;
    logic             errFlag;
    logic [`XLEN-1:0] regWindow [`REG_COUNT-1:0];

    logic [31:0] stim [MaxVec*Cols]; // flat array of Cols words per vector
    int numVec;
    int cycleLimit = 1000; // replaced once the vectors are counted
    int cycles     = 0;
    int testErrs   = 0;    // failed checks in the current test
    int passCount  = 0;
    int failCount  = 0;

    rvCore DUT (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .aluResult   (aluResult),
        .zeroFlag    (zeroFlag),
        .branchTaken (branchTaken),
        .errFlag     (errFlag),
        .regWindow   (regWindow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // stops a run that never reaches its end
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s expected %h got %h", name, exp, got);
            testErrs++;
        end
    endtask

    task automatic finishTest(input string label);
        if (testErrs == 0) begin
            passCount++;
            $display("%s: pass", label);
        end else begin
            failCount++;
            $display("%s: FAIL, %0d check(s) wrong", label, testErrs);
        end
        testErrs = 0;
    endtask

    // two reset cycles then every register must read zero
    task automatic resetAndCheck(input string label);
        reset       = 1'b1;
        instruction = 32'h00000013; // addi x0, x0, 0
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            checkValue($sformatf("regWindow[%0d]", r), regWindow[r], '0);
        end
        finishTest(label);
    endtask

    // entered 1 ns after a rising edge and left 1 ns after the next one
    task automatic runVector(input int v);
        logic [31:0] instr;
        logic [31:0] expAlu;
        logic [31:0] expFlags;
        logic [31:0] regIdx;
        logic [31:0] expReg;
        instr    = stim[v*Cols];
        expAlu   = stim[v*Cols+1];
        expFlags = stim[v*Cols+2]; // zero flag in bit 2 then taken then error
        regIdx   = stim[v*Cols+3];
        expReg   = stim[v*Cols+4];
        instruction = instr;
        #2; // 1 ns before the edge
        checkValue("aluResult", aluResult, expAlu);
        checkValue("zeroFlag", 32'(zeroFlag), 32'(expFlags[2]));
        checkValue("branchTaken", 32'(branchTaken), 32'(expFlags[1]));
        checkValue("errFlag", 32'(errFlag), 32'(expFlags[0]));
        @(posedge clk);
        #1; // write-back has landed
        checkValue($sformatf("regWindow[%0d]", regIdx), regWindow[regIdx[`REG_AW-1:0]],
                   expReg);
        finishTest($sformatf("vector %0d, instruction %h", v, instr));
    endtask

    initial begin
        reset       = 1'b1;
        instruction = 32'h00000013; // addi x0, x0, 0
        for (int i = 0; i < MaxVec*Cols; i++) begin
            stim[i] = EndMark;
        end
        $readmemh("rvCore_stimulus.txt", stim);
        numVec = 0;
        while (numVec < MaxVec && stim[numVec*Cols] != EndMark) begin
            numVec++;
        end
        cycleLimit = 2 * numVec + 20;
        if (numVec == 0) begin
            $display("no vectors could be read from the stimulus file");
            failCount++;
        end

        resetAndCheck("reset clears all registers");

        for (int v = 0; v < numVec; v++) begin
            runVector(v);
        end

        // the vectors left many registers nonzero
        resetAndCheck("reset clears written registers");

        $display("summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* rvCore.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCore (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] instruction, // held for one cycle
    output logic [`XLEN-1:0] aluResult,
    output logic             zeroFlag,    // alu result is zero
    output logic             branchTaken, // branch condition holds
    output logic             errFlag,     // unsupported instruction
    output logic [`XLEN-1:0] regWindow [`REG_COUNT-1:0]
);

    decodeIf decBus ();
    execIf   exeBus ();

    logic [`XLEN-1:0] regA;   // rs1 value
    logic [`XLEN-1:0] regB;   // rs2 value
    logic [`XLEN-1:0] wbData; // value written to rd

    decodeStage decode (
        .instruction (instruction),
        .dec         (decBus)
    );

    regFile regs (
        .clk         (clk),
        .reset       (reset),
        .readAddrA   (decBus.rs1),
        .readAddrB   (decBus.rs2),
        .writeAddr   (decBus.rd),
        .writeEnable (decBus.ctrl.regWrite),
        .writeData   (wbData),
        .readDataA   (regA),
        .readDataB   (regB),
        .regWindow   (regWindow)
    );

    executeStage execute (
        .dec  (decBus),
        .regA (regA),
        .regB (regB),
        .exe  (exeBus)
    );

    memWbStage memWb (
        .clk       (clk),
        .reset     (reset),
        .dec       (decBus),
        .exe       (exeBus),
        .writeData (wbData)
    );

    assign aluResult   = exeBus.aluResult;
    assign zeroFlag    = exeBus.zero;
    assign branchTaken = exeBus.branchTaken;
    assign errFlag     = exeBus.error;

endmodule

/* memWbStage.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module memWbStage (
    input  logic             clk,
    input  logic             reset,
    decodeIf.dst             dec,      // size, immediate, control
    execIf.dst               exe,      // address and store data
    output logic [`XLEN-1:0] writeData // to register file
);

    localparam int Lanes = `XLEN / 8;           // byte lanes per word
    localparam int OffW  = $clog2(Lanes);       // byte offset bits
    localparam int AddrW = $clog2(`DMEM_WORDS); // word index bits

    logic [`XLEN-1:0]  mem [`DMEM_WORDS];
    rvIsaPkg::memSizeT size;
    logic [AddrW-1:0]  wordAddr;
    logic [OffW-1:0]   byteOff;
    logic [Lanes-1:0]  laneEn;   // bytes touched by a store
    logic [`XLEN-1:0]  laneData; // store data replicated over lanes
    logic [`XLEN-1:0]  memWord;
    logic [7:0]        loadByte;
    logic [15:0]       loadHalf;
    logic [`XLEN-1:0]  loadData;

    assign size     = rvIsaPkg::memSizeT'(dec.funct3);
    assign wordAddr = exe.aluResult[OffW +: AddrW]; // upper address bits dropped
    assign byteOff  = exe.aluResult[OffW-1:0];

    always_comb begin
        case (size)
            rvIsaPkg::BYTE, rvIsaPkg::BYTE_U: begin
                laneEn   = Lanes'(1) << byteOff;
                laneData = {Lanes{exe.storeData[7:0]}};
            end
            rvIsaPkg::HALF, rvIsaPkg::HALF_U: begin
                laneEn   = Lanes'(2'b11) << {byteOff[OffW-1:1], 1'b0}; // aligned pair
                laneData = {(Lanes/2){exe.storeData[15:0]}};
            end
            default: begin
                laneEn   = '1; // full word
                laneData = exe.storeData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (dec.ctrl.memWrite) begin
            for (int l = 0; l < Lanes; l++) begin
                if (laneEn[l]) begin
                    mem[wordAddr][8*l +: 8] <= laneData[8*l +: 8];
                end
            end
        end
    end

    // read path, select lane then extend
    assign memWord  = mem[wordAddr];
    assign loadByte = memWord[{byteOff, 3'b000} +: 8];
    assign loadHalf = memWord[{byteOff[OffW-1:1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            rvIsaPkg::BYTE:   loadData = {{(`XLEN-8){loadByte[7]}}, loadByte};
            rvIsaPkg::HALF:   loadData = {{(`XLEN-16){loadHalf[15]}}, loadHalf};
            rvIsaPkg::BYTE_U: loadData = {{(`XLEN-8){1'b0}}, loadByte};
            rvIsaPkg::HALF_U: loadData = {{(`XLEN-16){1'b0}}, loadHalf};
            default:          loadData = memWord;
        endcase
        if (!dec.ctrl.memRead) begin
            loadData = '0; // no load this cycle
        end
    end

    // write-back source
    always_comb begin
        case (dec.ctrl.wbSrc)
            rvCtrlPkg::MEM: writeData = loadData;
            rvCtrlPkg::IMM: writeData = dec.imm;
            default:        writeData = exe.aluResult;
        endcase
    end

    // decode never asks for a load and a store at once
    assert property (@(posedge clk) disable iff (reset)
                     !(dec.ctrl.memRead && dec.ctrl.memWrite))
        else $error("memRead and memWrite both set");

endmodule

/* executeStage.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module executeStage (
    decodeIf.dst             dec,  // operation, immediate, control
    input  logic [`XLEN-1:0] regA, // rs1 value
    input  logic [`XLEN-1:0] regB, // rs2 value
    execIf.src               exe   // results to memory stage
);

    localparam int ShW = $clog2(`XLEN); // shift amount bits

    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] result;
    logic [ShW-1:0]   shamt;
    logic             signedLt;
    logic             unsignedLt;
    logic             cond; // branch condition before branch gating

    assign opB        = dec.ctrl.aluSrc ? dec.imm : regB;
    assign shamt      = opB[ShW-1:0];
    assign signedLt   = $signed(regA) < $signed(opB);
    assign unsignedLt = regA < opB;

    always_comb begin
        result = regA - opB; // branches report the difference
        cond   = 1'b0;
        case (dec.aluOp)
            rvIsaPkg::ADD:  result = regA + opB;
            rvIsaPkg::SUB:  result = regA - opB;
            rvIsaPkg::SLL:  result = regA << shamt;
            rvIsaPkg::SLT:  result = `XLEN'(signedLt);
            rvIsaPkg::SLTU: result = `XLEN'(unsignedLt);
            rvIsaPkg::XOR:  result = regA ^ opB;
            rvIsaPkg::SRL:  result = regA >> shamt;
            rvIsaPkg::SRA:  result = $signed(regA) >>> shamt; // keeps sign bit
            rvIsaPkg::OR:   result = regA | opB;
            rvIsaPkg::AND:  result = regA & opB;
            rvIsaPkg::BEQ:  cond = (regA == opB);
            rvIsaPkg::BNE:  cond = (regA != opB);
            rvIsaPkg::BLT:  cond = signedLt;
            rvIsaPkg::BGE:  cond = !signedLt;
            rvIsaPkg::BLTU: cond = unsignedLt;
            rvIsaPkg::BGEU: cond = !unsignedLt;
        endcase
    end

    assign exe.aluResult   = result;
    assign exe.storeData   = regB;                     // stores write rs2
    assign exe.zero        = (result == '0);
    assign exe.branchTaken = cond & dec.ctrl.branch;   // only real branches
    assign exe.error       = dec.ctrl.invalid;

endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module regFile (
    input  logic               clk,
    input  logic               reset,
    input  logic [`REG_AW-1:0] readAddrA,   // rs1
    input  logic [`REG_AW-1:0] readAddrB,   // rs2
    input  logic [`REG_AW-1:0] writeAddr,   // rd
    input  logic               writeEnable,
    input  logic [`XLEN-1:0]   writeData,
    output logic [`XLEN-1:0]   readDataA,
    output logic [`XLEN-1:0]   readDataB,
    output logic [`XLEN-1:0]   regWindow [`REG_COUNT-1:0] // every register, for observation
);

    logic [`XLEN-1:0] regs [`REG_COUNT-1:0];

    // combinational reads, x0 held at zero by the write logic
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];
    assign regWindow = regs;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin // x0 ignores writes
            regs[writeAddr] <= writeData;
        end
    end

    // x0 must survive every write-back
    assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module decodeStage (
    input  logic [`XLEN-1:0] instruction, // raw instruction word
    decodeIf.src             dec          // decoded fields out
);

    rvIsaPkg::opcodeT opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] immI, immS, immB, immU;

    // shared by OP and OP-IMM, sub only exists for register form
    function automatic rvIsaPkg::aluOpT arithOp(
        input logic [2:0] f3,
        input logic       alt,  // funct7 bit 5
        input logic       isReg // register-register form
    );
        case (f3)
            3'b000:  arithOp = (alt && isReg) ? rvIsaPkg::SUB : rvIsaPkg::ADD;
            3'b001:  arithOp = rvIsaPkg::SLL;
            3'b010:  arithOp = rvIsaPkg::SLT;
            3'b011:  arithOp = rvIsaPkg::SLTU;
            3'b100:  arithOp = rvIsaPkg::XOR;
            3'b110:  arithOp = rvIsaPkg::OR;
            3'b111:  arithOp = rvIsaPkg::AND;
            default: arithOp = alt ? rvIsaPkg::SRA : rvIsaPkg::SRL; // 101, shift right
        endcase
    endfunction

    assign opcode = rvIsaPkg::opcodeT'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign dec.rd     = instruction[11:7];
    assign dec.rs1    = instruction[19:15];
    assign dec.rs2    = instruction[24:20];
    assign dec.funct3 = funct3;

    // immediates per format, all sign extended from bit 31
    assign immI = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
    assign immS = {{(`XLEN-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{(`XLEN-13){instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};

    always_comb begin
        dec.ctrl  = '0;            // all enables off, wbSrc alu
        dec.imm   = immI;          // i-type unless noted
        dec.aluOp = rvIsaPkg::ADD; // address adder by default
        case (opcode)
            rvIsaPkg::OP: begin
                dec.ctrl.regWrite = 1'b1;
                dec.aluOp         = arithOp(funct3, funct7[5], 1'b1);
            end
            rvIsaPkg::OP_IMM: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
                dec.aluOp         = arithOp(funct3, funct7[5], 1'b0); // no subi
            end
            rvIsaPkg::LUI: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
                dec.ctrl.wbSrc    = rvCtrlPkg::IMM; // rd gets the upper immediate
                dec.imm           = immU;
            end
            rvIsaPkg::LOAD: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.aluSrc   = 1'b1;
                dec.ctrl.memRead  = 1'b1;
                dec.ctrl.wbSrc    = rvCtrlPkg::MEM;
            end
            rvIsaPkg::STORE: begin
                dec.ctrl.aluSrc   = 1'b1;
                dec.ctrl.memWrite = 1'b1;
                dec.imm           = immS;
            end
            rvIsaPkg::BRANCH: begin
                dec.ctrl.branch = 1'b1; // compares rs1 with rs2
                dec.imm         = immB;
                case (funct3)
                    3'b001:  dec.aluOp = rvIsaPkg::BNE;
                    3'b100:  dec.aluOp = rvIsaPkg::BLT;
                    3'b101:  dec.aluOp = rvIsaPkg::BGE;
                    3'b110:  dec.aluOp = rvIsaPkg::BLTU;
                    3'b111:  dec.aluOp = rvIsaPkg::BGEU;
                    default: dec.aluOp = rvIsaPkg::BEQ;
                endcase
            end
            default: dec.ctrl.invalid = 1'b1; // jal, jalr, auipc, system
        endcase
    end

    // an unsupported word must not reach the register file or memory
    assert property (@(instruction) dec.ctrl.invalid |-> !(dec.ctrl.regWrite || dec.ctrl.memWrite))
        else $error("invalid opcode left a write enable set");

endmodule

/* rvStageIf.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

// decoded fields, decode to execute and memory stages
interface decodeIf;
    logic [`REG_AW-1:0]  rs1;    // source a address
    logic [`REG_AW-1:0]  rs2;    // source b address
    logic [`REG_AW-1:0]  rd;     // destination address
    logic [2:0]          funct3; // load/store size, branch kind
    logic [`XLEN-1:0]    imm;    // sign extended immediate
    rvIsaPkg::aluOpT     aluOp;  // resolved operation
    rvCtrlPkg::ctrlT     ctrl;   // control word

    modport src (output rs1, rs2, rd, funct3, imm, aluOp, ctrl);
    modport dst (input  rs1, rs2, rd, funct3, imm, aluOp, ctrl);
endinterface

// execute results, execute to memory stage
interface execIf;
    logic [`XLEN-1:0] aluResult;   // result, also memory address
    logic [`XLEN-1:0] storeData;   // register b for stores
    logic             zero;        // result is zero
    logic             branchTaken; // branch condition holds
    logic             error;       // unsupported instruction

    modport src (output aluResult, storeData, zero, branchTaken, error);
    modport dst (input  aluResult, storeData, zero, branchTaken, error);
endinterface

/* rvCtrlPkg.sv */
package rvCtrlPkg;

    // where the register write data comes from
    typedef enum logic [1:0] {
        ALU = 2'd0, // alu result
        MEM = 2'd1, // load data
        IMM = 2'd2  // immediate, for lui
    } wbSrcT;

    // control word produced by decode
    typedef struct packed {
        logic  aluSrc;   // operand b is the immediate
        logic  regWrite; // write rd at the clock edge
        logic  memRead;  // load
        logic  memWrite; // store
        logic  branch;   // conditional branch
        wbSrcT wbSrc;    // write-back source select
        logic  invalid;  // unsupported opcode
    } ctrlT;

endpackage

/* rvIsaPkg.sv */
package rvIsaPkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // register-register arithmetic
        OP_IMM = 7'b0010011, // register-immediate arithmetic
        LUI    = 7'b0110111, // load upper immediate
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011  // conditional branch, flag only
    } opcodeT;

    // alu and branch compare operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,  SUB  = 4'd1,  SLL  = 4'd2,  SLT  = 4'd3,
        SLTU = 4'd4,  XOR  = 4'd5,  SRL  = 4'd6,  SRA  = 4'd7,
        OR   = 4'd8,  AND  = 4'd9,
        BEQ  = 4'd10, BNE  = 4'd11, BLT  = 4'd12, BGE  = 4'd13,
        BLTU = 4'd14, BGEU = 4'd15
    } aluOpT;

    // funct3 access size for loads and stores
    typedef enum logic [2:0] {
        BYTE   = 3'b000, // lb / sb
        HALF   = 3'b001, // lh / sh
        WORD   = 3'b010, // lw / sw
        BYTE_U = 3'b100, // lbu
        HALF_U = 3'b101  // lhu
    } memSizeT;

endpackage

/* rvCore_defines.svh */
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

`define XLEN       32 // data path width
`define REG_COUNT  32 // architectural registers
`define REG_AW     5  // register address bits
`define DMEM_WORDS 64 // data memory depth, power of two

`endif
